//--- obs_pkg.sv
// Shared encodings and widths for the bus observation blocks
// Import into any module that decodes controller PC sources or sizes counters

`default_nettype none

package obs_pkg;

  // --------------------------------------------------------------------------
  // Program-counter source select
  // --------------------------------------------------------------------------

  // Width of the controller's PC mux select
  localparam int unsigned PC_MUX_W = 4;

  // Encoding as driven by the core controller on pc_mux
  // Trap sources sit in the upper half of the code space
  typedef enum logic [PC_MUX_W-1:0] {
    PC_BOOT     = 4'b0000,
    PC_MRET     = 4'b0001,
    PC_DRET     = 4'b0010,
    PC_FENCEI   = 4'b0011,
    PC_JUMP     = 4'b0100,
    PC_BRANCH   = 4'b0101,
    // Synchronous exception taken in writeback
    PC_TRAP_EXC = 4'b1000,
    // Interrupt entry
    PC_TRAP_IRQ = 4'b1001,
    // Debug entry caused by an exception
    PC_TRAP_DBE = 4'b1011,
    // Non-maskable interrupt entry
    PC_TRAP_NMI = 4'b1100
  } pc_mux_e;

  // --------------------------------------------------------------------------
  // Phase monitor sizing
  // --------------------------------------------------------------------------

  // Outstanding address phase counter, counts 0 to 15 and then saturates
  localparam int unsigned OUTST_CNT_W = 4;

endpackage : obs_pkg

`default_nettype wire

//--- obi_phase_monitor.sv
// Passive tracker for one OBI request/response channel
// Flags phases longer than one cycle and counts address phases awaiting response

`timescale 1ns/10ps
`default_nettype none

module obi_phase_monitor #(
  // Counter width, the count saturates at all ones
  parameter int unsigned CntWidth = obs_pkg::OUTST_CNT_W
) (
  input  logic                clk_i,
  input  logic                rst_ni,

  // Observed channel handshake
  input  logic                req_i,
  input  logic                gnt_i,
  input  logic                rvalid_i,
  input  logic                rready_i,

  // Address phase that was not granted in its first cycle
  output logic                addr_ph_cont_o,
  // Response phase that was not accepted in its first cycle
  output logic                resp_ph_cont_o,
  // Accepted address phases still waiting for a response
  output logic [CntWidth-1:0] outst_cnt_o,
  // Response accepted with nothing outstanding
  output logic                orphan_rsp_o
);

  // --------------------------------------------------------------------------
  // Phase decode
  // --------------------------------------------------------------------------

  logic                addr_acc;
  logic                rsp_acc;
  logic                cnt_at_max;
  logic                cnt_at_zero;

  logic                addr_ph_cont_q;
  logic                resp_ph_cont_q;
  logic [CntWidth-1:0] outst_cnt_q;
  logic                orphan_rsp_q;

  // Address phase ends on req and gnt
  assign addr_acc    = req_i & gnt_i;
  // Response phase ends on rvalid and rready
  assign rsp_acc     = rvalid_i & rready_i;

  assign cnt_at_max  = (outst_cnt_q == {CntWidth{1'b1}});
  assign cnt_at_zero = (outst_cnt_q == '0);

  // --------------------------------------------------------------------------
  // Registered indicators
  // --------------------------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_ph_cont_q <= 1'b0;
      resp_ph_cont_q <= 1'b0;
      orphan_rsp_q   <= 1'b0;
    end else begin
      // Request left waiting for a grant
      addr_ph_cont_q <= req_i & ~gnt_i;
      // Response held back by the receiver
      resp_ph_cont_q <= rvalid_i & ~rready_i;
      // Single-cycle pulse, response with no matching request
      orphan_rsp_q   <= rsp_acc & ~addr_acc & cnt_at_zero;
    end
  end

  // Saturating count, simultaneous accept and response leaves it alone
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outst_cnt_q <= '0;
    end else if (addr_acc && !rsp_acc && !cnt_at_max) begin
      outst_cnt_q <= outst_cnt_q + 1'b1;
    end else if (rsp_acc && !addr_acc && !cnt_at_zero) begin
      outst_cnt_q <= outst_cnt_q - 1'b1;
    end
  end

  assign addr_ph_cont_o = addr_ph_cont_q;
  assign resp_ph_cont_o = resp_ph_cont_q;
  assign outst_cnt_o    = outst_cnt_q;
  assign orphan_rsp_o   = orphan_rsp_q;

  // --------------------------------------------------------------------------
  // Assertions
  // --------------------------------------------------------------------------

  // OBI legality, a grant only answers a pending request
  a_gnt_needs_req : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    gnt_i |-> req_i
  );

  // Count moves by at most one step between consecutive cycles
  a_cnt_single_step : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (int'(outst_cnt_q) - int'($past(outst_cnt_q))) inside {-1, 0, 1}
  );

endmodule : obi_phase_monitor

`default_nettype wire

//--- trap_req_tracker.sv
// Watches for data-bus requests between a writeback trap and the next retirement
// Used when checking exception timing of multi-operation loads and stores

`timescale 1ns/10ps
`default_nettype none

module trap_req_tracker (
  input  logic            clk_i,
  input  logic            rst_ni,

  // Controller PC update
  input  logic            pc_set_i,
  input  obs_pkg::pc_mux_e pc_mux_i,

  // Retirement strobe from the RVFI side
  input  logic            rvfi_valid_i,

  // Data bus address phase handshake
  input  logic            data_req_i,
  input  logic            data_gnt_i,

  // A data request was seen after the trap and before retirement
  output logic            req_after_exception_o
);

  import obs_pkg::*;

  // --------------------------------------------------------------------------
  // State
  // --------------------------------------------------------------------------

  // Data grant seen in the previous cycle
  logic data_gnt_q;
  // Set from trap until the next retirement
  logic exc_active_q;
  logic req_after_exc_q;

  logic trap_taken;
  logic req_after_gnt;

  // Only exception and debug-exception entries count as traps here
  assign trap_taken = pc_set_i && ((pc_mux_i == PC_TRAP_EXC) || (pc_mux_i == PC_TRAP_DBE));

  // New request right after a completed address phase
  assign req_after_gnt = data_req_i & data_gnt_q;

  // --------------------------------------------------------------------------
  // Priority update
  // --------------------------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      data_gnt_q      <= 1'b0;
      exc_active_q    <= 1'b0;
      req_after_exc_q <= 1'b0;
    end else begin
      data_gnt_q <= data_gnt_i;

      if (trap_taken) begin
        // Trap in writeback opens the window
        exc_active_q <= 1'b1;
        if (req_after_gnt) begin
          req_after_exc_q <= 1'b1;
        end
      end else if (rvfi_valid_i) begin
        // Retirement closes the window and clears the flag
        exc_active_q    <= 1'b0;
        req_after_exc_q <= 1'b0;
      end else if (exc_active_q && req_after_gnt) begin
        req_after_exc_q <= 1'b1;
      end
      // Flag holds otherwise
    end
  end

  assign req_after_exception_o = req_after_exc_q;

  // --------------------------------------------------------------------------
  // Assertions
  // --------------------------------------------------------------------------

  // Flag only rises out of an open trap window or the trap cycle itself
  a_flag_needs_trap : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $rose(req_after_exc_q) |-> $past(exc_active_q || trap_taken)
  );

endmodule : trap_req_tracker

`default_nettype wire

//--- support_logic.sv
// Top level of the bus observation block, monitors data, instr and abiim channels
// Also tracks data requests after a writeback trap, all outputs are registered

`timescale 1ns/10ps
`default_nettype none

module support_logic (
  input  logic                              clk_i,
  input  logic                              rst_ni,

  // --------------------------------------------------------------------------
  // Data bus
  // --------------------------------------------------------------------------

  input  logic                              data_req_i,
  input  logic                              data_gnt_i,
  input  logic                              data_rvalid_i,
  input  logic                              data_rready_i,
  output logic                              data_addr_ph_cont_o,
  output logic                              data_resp_ph_cont_o,
  output logic [obs_pkg::OUTST_CNT_W-1:0]   data_outst_cnt_o,
  output logic                              data_orphan_rsp_o,

  // --------------------------------------------------------------------------
  // Instruction bus
  // --------------------------------------------------------------------------

  input  logic                              instr_req_i,
  input  logic                              instr_gnt_i,
  input  logic                              instr_rvalid_i,
  input  logic                              instr_rready_i,
  output logic                              instr_addr_ph_cont_o,
  output logic                              instr_resp_ph_cont_o,
  output logic [obs_pkg::OUTST_CNT_W-1:0]   instr_outst_cnt_o,
  output logic                              instr_orphan_rsp_o,

  // --------------------------------------------------------------------------
  // Alignment buffer to instruction-side MPU link
  // --------------------------------------------------------------------------

  input  logic                              abiim_req_i,
  input  logic                              abiim_gnt_i,
  input  logic                              abiim_rvalid_i,
  input  logic                              abiim_rready_i,
  output logic                              abiim_addr_ph_cont_o,
  output logic                              abiim_resp_ph_cont_o,
  output logic [obs_pkg::OUTST_CNT_W-1:0]   abiim_outst_cnt_o,
  output logic                              abiim_orphan_rsp_o,

  // --------------------------------------------------------------------------
  // Controller and retirement
  // --------------------------------------------------------------------------

  // PC update strobe and its source
  input  logic                              pc_set_i,
  input  obs_pkg::pc_mux_e                  pc_mux_i,
  // One instruction retired this cycle
  input  logic                              rvfi_valid_i,
  // Data request seen inside the trap window
  output logic                              req_after_exception_o
);

  import obs_pkg::*;

  // --------------------------------------------------------------------------
  // Channel monitors
  // --------------------------------------------------------------------------

  // Data bus, shared with the trap tracker below
  obi_phase_monitor #(
    .CntWidth       (OUTST_CNT_W)
  ) u_data_mon (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (data_req_i),
    .gnt_i          (data_gnt_i),
    .rvalid_i       (data_rvalid_i),
    .rready_i       (data_rready_i),
    .addr_ph_cont_o (data_addr_ph_cont_o),
    .resp_ph_cont_o (data_resp_ph_cont_o),
    .outst_cnt_o    (data_outst_cnt_o),
    .orphan_rsp_o   (data_orphan_rsp_o)
  );

  // Instruction fetch bus
  obi_phase_monitor #(
    .CntWidth       (OUTST_CNT_W)
  ) u_instr_mon (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (instr_req_i),
    .gnt_i          (instr_gnt_i),
    .rvalid_i       (instr_rvalid_i),
    .rready_i       (instr_rready_i),
    .addr_ph_cont_o (instr_addr_ph_cont_o),
    .resp_ph_cont_o (instr_resp_ph_cont_o),
    .outst_cnt_o    (instr_outst_cnt_o),
    .orphan_rsp_o   (instr_orphan_rsp_o)
  );

  // Internal link between alignment buffer and instruction MPU
  obi_phase_monitor #(
    .CntWidth       (OUTST_CNT_W)
  ) u_abiim_mon (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (abiim_req_i),
    .gnt_i          (abiim_gnt_i),
    .rvalid_i       (abiim_rvalid_i),
    .rready_i       (abiim_rready_i),
    .addr_ph_cont_o (abiim_addr_ph_cont_o),
    .resp_ph_cont_o (abiim_resp_ph_cont_o),
    .outst_cnt_o    (abiim_outst_cnt_o),
    .orphan_rsp_o   (abiim_orphan_rsp_o)
  );

  // --------------------------------------------------------------------------
  // Trap window tracker
  // --------------------------------------------------------------------------

  // Only the data channel address handshake feeds the tracker
  trap_req_tracker u_trap_trk (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .pc_set_i              (pc_set_i),
    .pc_mux_i              (pc_mux_i),
    .rvfi_valid_i          (rvfi_valid_i),
    .data_req_i            (data_req_i),
    .data_gnt_i            (data_gnt_i),
    .req_after_exception_o (req_after_exception_o)
  );

endmodule : support_logic

`default_nettype wire

//--- tb_support_logic_vectors.svh
// Per-cycle vectors for the bus observation testbench, included inside its module
// Each row holds name, data/instr/abiim {req,gnt,rvalid,rready}, pc_set, pc_mux, rvfi_valid,
// then expected data/instr/abiim {addr_cont,resp_cont,cnt[3:0],orphan}, req_after_exception

`ifndef TB_SUPPORT_LOGIC_VECTORS_SVH
`define TB_SUPPORT_LOGIC_VECTORS_SVH

  task automatic load_vectors;
    // ------------------------------------------------------------------------
    // Reset state, continued phases, instr count up and hold
    // ------------------------------------------------------------------------
    add_row("reset_idle", 4'b0000, 4'b0000, 4'b0000, 1'b0, PC_BOOT, 1'b0,
            7'b0_0_0000_0, 7'b0_0_0000_0, 7'b0_0_0000_0, 1'b0);
    // abiim is granted every cycle from here up to saturation
    add_row("data_req_wait", 4'b1000, 4'b1100, 4'b1100, 1'b0, PC_BOOT, 1'b0,
            7'b1_0_0000_0, 7'b0_0_0001_0, 7'b0_0_0001_0, 1'b0);
    add_row("data_grant", 4'b1100, 4'b1100, 4'b1100, 1'b0, PC_BOOT, 1'b0,
            7'b0_0_0001_0, 7'b0_0_0010_0, 7'b0_0_0010_0, 1'b0);
    add_row("data_rsp_wait", 4'b0010, 4'b1100, 4'b1100, 1'b0, PC_BOOT, 1'b0,
            7'b0_1_0001_0, 7'b0_0_0011_0, 7'b0_0_0011_0, 1'b0);
    // Address and response together, instr count holds at 3
    add_row("instr_addr_and_rsp", 4'b0011, 4'b1111, 4'b1100, 1'b0, PC_BOOT, 1'b0,
            7'b0_0_0000_0, 7'b0_0_0011_0, 7'b0_0_0100_0, 1'b0);
    // Response at count 0 on data
    add_row("data_orphan_rsp", 4'b0011, 4'b0011, 4'b1100, 1'b0, PC_BOOT, 1'b0,
            7'b0_0_0000_1, 7'b0_0_0010_0, 7'b0_0_0101_0, 1'b0);
    add_row("orphan_clears", 4'b0000, 4'b0011, 4'b1100, 1'b0, PC_BOOT, 1'b0,
            7'b0_0_0000_0, 7'b0_0_0001_0, 7'b0_0_0110_0, 1'b0);

    // ------------------------------------------------------------------------
    // Trap window on the data bus
    // ------------------------------------------------------------------------
    add_row("grant_before_trap", 4'b1100, 4'b0011, 4'b1100, 1'b0, PC_BOOT, 1'b0,
            7'b0_0_0001_0, 7'b0_0_0000_0, 7'b0_0_0111_0, 1'b0);
    // Exception trap with req right after a grant
    add_row("trap_exc_with_req", 4'b1000, 4'b1000, 4'b1100, 1'b1, PC_TRAP_EXC, 1'b0,
            7'b1_0_0001_0, 7'b1_0_0000_0, 7'b0_0_1000_0, 1'b1);
    add_row("retire_clears", 4'b0011, 4'b1100, 4'b1100, 1'b0, PC_BOOT, 1'b1,
            7'b0_0_0000_0, 7'b0_0_0001_0, 7'b0_0_1001_0, 1'b0);
    add_row("grant_before_irq", 4'b1100, 4'b0010, 4'b1100, 1'b0, PC_BOOT, 1'b0,
            7'b0_0_0001_0, 7'b0_1_0001_0, 7'b0_0_1010_0, 1'b0);
    // Interrupt entry is no trap for the tracker
    add_row("trap_irq_ignored", 4'b1000, 4'b0011, 4'b1100, 1'b1, PC_TRAP_IRQ, 1'b0,
            7'b1_0_0001_0, 7'b0_0_0000_0, 7'b0_0_1011_0, 1'b0);
    add_row("irq_rsp", 4'b0011, 4'b0000, 4'b1100, 1'b0, PC_BOOT, 1'b0,
            7'b0_0_0000_0, 7'b0_0_0000_0, 7'b0_0_1100_0, 1'b0);
    // Debug exception opens the window without a request
    add_row("trap_dbe_no_req", 4'b0000, 4'b0000, 4'b1100, 1'b1, PC_TRAP_DBE, 1'b0,
            7'b0_0_0000_0, 7'b0_0_0000_0, 7'b0_0_1101_0, 1'b0);
    add_row("dbe_grant", 4'b1100, 4'b0000, 4'b1100, 1'b0, PC_BOOT, 1'b0,
            7'b0_0_0001_0, 7'b0_0_0000_0, 7'b0_0_1110_0, 1'b0);
    add_row("dbe_req_after_gnt", 4'b1000, 4'b0000, 4'b1100, 1'b0, PC_BOOT, 1'b0,
            7'b1_0_0001_0, 7'b0_0_0000_0, 7'b0_0_1111_0, 1'b1);
    // Sixteenth abiim grant, count stays at 15
    add_row("abiim_saturate", 4'b0011, 4'b0000, 4'b1100, 1'b0, PC_BOOT, 1'b0,
            7'b0_0_0000_0, 7'b0_0_0000_0, 7'b0_0_1111_0, 1'b1);
    add_row("retire_clears_dbe", 4'b0000, 4'b0000, 4'b1000, 1'b0, PC_BOOT, 1'b1,
            7'b0_0_0000_0, 7'b0_0_0000_0, 7'b1_0_1111_0, 1'b0);
    // Grant ends the abiim wait while the response stalls, count still saturated
    add_row("abiim_rsp_wait", 4'b0000, 4'b0000, 4'b1110, 1'b0, PC_BOOT, 1'b0,
            7'b0_0_0000_0, 7'b0_0_0000_0, 7'b0_1_1111_0, 1'b0);
    add_row("abiim_rsp_accept", 4'b0000, 4'b0000, 4'b0011, 1'b0, PC_BOOT, 1'b0,
            7'b0_0_0000_0, 7'b0_0_0000_0, 7'b0_0_1110_0, 1'b0);
  endtask

`endif

//--- tb_support_logic.sv
// Table-driven testbench for the bus observation top level
// Drives one vector per cycle on the falling edge and checks it one cycle later

`timescale 1ns/10ps
`default_nettype none

module tb_support_logic;

  import obs_pkg::*;

  localparam int CLK_PERIOD     = 10;
  localparam int RESET_CYCLES   = 3;
  localparam int TIMEOUT_CYCLES = 20;
  localparam int NUM_ROWS       = 20;

  logic       clk_i;
  logic       rst_ni;
  // Channel inputs as {req, gnt, rvalid, rready}
  logic [3:0] data_in;
  logic [3:0] instr_in;
  logic [3:0] abiim_in;
  logic       pc_set;
  pc_mux_e    pc_mux;
  logic       rvfi_valid;
  // Channel outputs as {addr_ph_cont, resp_ph_cont, outst_cnt, orphan_rsp}
  logic [6:0] data_obs;
  logic [6:0] instr_obs;
  logic [6:0] abiim_obs;
  logic       req_after_exc;

  // Vector table, one entry per cycle
  string       name_q[$];
  logic [17:0] stim_q[$];
  logic [21:0] exp_q[$];

  int errors;
  int checks;

  support_logic support_logic_i (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .data_req_i            (data_in[3]),
    .data_gnt_i            (data_in[2]),
    .data_rvalid_i         (data_in[1]),
    .data_rready_i         (data_in[0]),
    .data_addr_ph_cont_o   (data_obs[6]),
    .data_resp_ph_cont_o   (data_obs[5]),
    .data_outst_cnt_o      (data_obs[4:1]),
    .data_orphan_rsp_o     (data_obs[0]),
    .instr_req_i           (instr_in[3]),
    .instr_gnt_i           (instr_in[2]),
    .instr_rvalid_i        (instr_in[1]),
    .instr_rready_i        (instr_in[0]),
    .instr_addr_ph_cont_o  (instr_obs[6]),
    .instr_resp_ph_cont_o  (instr_obs[5]),
    .instr_outst_cnt_o     (instr_obs[4:1]),
    .instr_orphan_rsp_o    (instr_obs[0]),
    .abiim_req_i           (abiim_in[3]),
    .abiim_gnt_i           (abiim_in[2]),
    .abiim_rvalid_i        (abiim_in[1]),
    .abiim_rready_i        (abiim_in[0]),
    .abiim_addr_ph_cont_o  (abiim_obs[6]),
    .abiim_resp_ph_cont_o  (abiim_obs[5]),
    .abiim_outst_cnt_o     (abiim_obs[4:1]),
    .abiim_orphan_rsp_o    (abiim_obs[0]),
    .pc_set_i              (pc_set),
    .pc_mux_i              (pc_mux),
    .rvfi_valid_i          (rvfi_valid),
    .req_after_exception_o (req_after_exc)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // Reset held for a few rising edges, released on a falling edge
  initial begin
    rst_ni = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
  end

  // --------------------------------------------------------------------------
  // Table handling
  // --------------------------------------------------------------------------

  task automatic add_row(input string name, input logic [3:0] d_in,
                         input logic [3:0] i_in, input logic [3:0] a_in,
                         input logic set, input pc_mux_e mux, input logic rvfi,
                         input logic [6:0] d_exp, input logic [6:0] i_exp,
                         input logic [6:0] a_exp, input logic rae);
    name_q.push_back(name);
    stim_q.push_back({d_in, i_in, a_in, set, mux, rvfi});
    exp_q.push_back({d_exp, i_exp, a_exp, rae});
  endtask

  `include "tb_support_logic_vectors.svh"

  task automatic apply_row(input int idx);
    data_in    = stim_q[idx][17:14];
    instr_in   = stim_q[idx][13:10];
    abiim_in   = stim_q[idx][9:6];
    pc_set     = stim_q[idx][5];
    pc_mux     = pc_mux_e'(stim_q[idx][4:1]);
    rvfi_valid = stim_q[idx][0];
  endtask

  task automatic check_field(input string name, input string field,
                             input logic [6:0] expected, input logic [6:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("MISMATCH %s %s expected %b actual %b", name, field, expected, actual);
    end
  endtask

  task automatic check_row(input int idx);
    logic [21:0] expected;
    expected = exp_q[idx];
    check_field(name_q[idx], "data", expected[21:15], data_obs);
    check_field(name_q[idx], "instr", expected[14:8], instr_obs);
    check_field(name_q[idx], "abiim", expected[7:1], abiim_obs);
    check_field(name_q[idx], "req_after_exception", {6'b0, expected[0]},
                {6'b0, req_after_exc});
  endtask

  // Summary line, then the verdict
  task automatic finish_run;
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------

  initial begin
    int wait_cycles;
    clk_i       = 1'b0;
    data_in     = '0;
    instr_in    = '0;
    abiim_in    = '0;
    pc_set      = 1'b0;
    pc_mux      = PC_BOOT;
    rvfi_valid  = 1'b0;
    errors      = 0;
    checks      = 0;
    wait_cycles = 0;
    load_vectors();
    if (name_q.size() != NUM_ROWS) begin
      errors++;
      $display("Vector table holds %0d rows instead of %0d", name_q.size(), NUM_ROWS);
    end
    while (!rst_ni && wait_cycles < TIMEOUT_CYCLES) begin
      @(negedge clk_i);
      wait_cycles++;
    end
    if (!rst_ni) begin
      errors++;
      $display("Reset was not released within %0d cycles", TIMEOUT_CYCLES);
    end else begin
      // Drive on one falling edge, check on the next
      for (int i = 0; i < name_q.size(); i++) begin
        apply_row(i);
        @(negedge clk_i);
        check_row(i);
      end
    end
    finish_run();
  end

endmodule : tb_support_logic

`default_nettype wire

//--- all.f
+incdir+.
obs_pkg.sv
obi_phase_monitor.sv
trap_req_tracker.sv
support_logic.sv
tb_support_logic.sv

//--- Makefile
# Verilator flow for the bus observation testbench
# compile builds the simulator, run checks its output, clean removes the build

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -sv --timescale 1ns/10ps \
		-f all.f --top-module tb_support_logic -Mdir obj_dir -o sim

# Status comes from the search for the pass line in the simulator output
run: compile
	@out="$$(./obj_dir/sim)"; echo "$$out"; echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf obj_dir
